/* logic/mcu_pkg.sv */
// mini mcu shared definitions
// bus widths, memory map, address views and target select
package mcu_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // one sram bank
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW    = $clog2(BANK_WORDS);

  localparam logic [ADDR_W-1:0] RAM_BASE    = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h2000_0000;

  // exit value register, the only mapped peripheral register
  localparam logic [1:0] EXIT_REG_IDX = 2'd0;

  typedef logic [DATA_W-1:0] mcu_data_t;

  typedef struct packed {
    logic [ADDR_W-BANK_AW-4:0] zero;
    logic                      bank;
    logic [BANK_AW-1:0]        word;
    logic [1:0]                byte_off;
  } ram_view_t;

  typedef struct packed {
    logic [3:0]  region;
    logic [23:0] unused;
    logic [1:0]  reg_idx;
    logic [1:0]  byte_off;
  } periph_view_t;

  // same address word, read as ram or as peripheral
  typedef union packed {
    ram_view_t    ram;
    periph_view_t periph;
  } mcu_addr_u;

  typedef enum logic [1:0] {
    TGT_RAM0,
    TGT_RAM1,
    TGT_EXIT,
    TGT_NONE
  } tgt_sel_e;

endpackage

/* logic/sram_bank.sv */
// word sram bank with byte enables
// obi slave, grants at once and answers one cycle later
module sram_bank #(
  parameter int unsigned NUM_WORDS = mcu_pkg::BANK_WORDS
) (
  input  logic                         clk_i,
  input  logic                         rst_i,

  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  logic [3:0]                   be_i,
  input  mcu_pkg::mcu_data_t           wdata_i,

  output logic                         gnt_o,
  output logic                         rvalid_o,
  output mcu_pkg::mcu_data_t           rdata_o
);

  import mcu_pkg::*;

  mcu_data_t mem_q [NUM_WORDS];
  logic      accept;

  assign gnt_o  = req_i;
  assign accept = req_i & gnt_o;

  // per byte lane write
  always_ff @(posedge clk_i) begin
    if (accept && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= accept;
    end
  end

  // exactly one response per accepted request
  a_rvalid_follows_accept: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rvalid_o == $past(accept & ~rst_i)
  ) else $error("sram_bank: rvalid out of step with accepted requests");

endmodule

/* logic/exit_ctrl.sv */
// exit control peripheral
// latches the program's exit value and raises a sticky valid flag
module exit_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                req_i,
  input  logic                we_i,
  input  mcu_pkg::mcu_addr_u  addr_i,
  input  logic [3:0]          be_i,
  input  mcu_pkg::mcu_data_t  wdata_i,

  output logic                gnt_o,
  output logic                rvalid_o,
  output mcu_pkg::mcu_data_t  rdata_o,
  output logic                err_o,

  output mcu_pkg::mcu_data_t  exit_value_o,
  output logic                exit_valid_o
);

  import mcu_pkg::*;

  logic accept;
  logic hit;

  assign gnt_o  = req_i;
  assign accept = req_i & gnt_o;
  assign hit    = (addr_i.periph.reg_idx == EXIT_REG_IDX);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o     <= 1'b0;
      err_o        <= 1'b0;
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
    end else begin
      rvalid_o <= accept;
      err_o    <= accept & ~hit;
      if (accept && we_i && hit) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            exit_value_o[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        exit_valid_o <= 1'b1;
      end
    end
  end

  // unmapped index reads back as zero
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_o <= hit ? exit_value_o : '0;
    end
  end

  a_exit_valid_sticky: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $fell(exit_valid_o) |-> $past(rst_i)
  ) else $error("exit_ctrl: exit_valid_o dropped outside reset");

endmodule

/* logic/system_bus.sv */
// system bus for one obi master
// decodes to two sram banks and exit control, merges responses in order
module system_bus (
  input  logic                        clk_i,
  input  logic                        rst_i,

  // master side
  input  logic                        req_i,
  input  logic                        we_i,
  input  mcu_pkg::mcu_addr_u          addr_i,
  input  logic [3:0]                  be_i,
  input  mcu_pkg::mcu_data_t          wdata_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output mcu_pkg::mcu_data_t          rdata_o,
  output logic                        err_o,

  // ram bank 0
  output logic                        ram0_req_o,
  output logic                        ram0_we_o,
  output logic [mcu_pkg::BANK_AW-1:0] ram0_addr_o,
  output logic [3:0]                  ram0_be_o,
  output mcu_pkg::mcu_data_t          ram0_wdata_o,
  input  logic                        ram0_gnt_i,
  input  logic                        ram0_rvalid_i,
  input  mcu_pkg::mcu_data_t          ram0_rdata_i,

  // ram bank 1
  output logic                        ram1_req_o,
  output logic                        ram1_we_o,
  output logic [mcu_pkg::BANK_AW-1:0] ram1_addr_o,
  output logic [3:0]                  ram1_be_o,
  output mcu_pkg::mcu_data_t          ram1_wdata_o,
  input  logic                        ram1_gnt_i,
  input  logic                        ram1_rvalid_i,
  input  mcu_pkg::mcu_data_t          ram1_rdata_i,

  // exit control
  output logic                        exit_req_o,
  output logic                        exit_we_o,
  output mcu_pkg::mcu_addr_u          exit_addr_o,
  output logic [3:0]                  exit_be_o,
  output mcu_pkg::mcu_data_t          exit_wdata_o,
  input  logic                        exit_gnt_i,
  input  logic                        exit_rvalid_i,
  input  mcu_pkg::mcu_data_t          exit_rdata_i,
  input  logic                        exit_err_i
);

  import mcu_pkg::*;

  tgt_sel_e tgt_d;
  tgt_sel_e tgt_q;
  logic     accept;
  logic     valid_q;

  // ram needs bits 31..11 clear, peripherals match on the top nibble
  always_comb begin
    tgt_d = TGT_NONE;
    if (addr_i.ram.zero == RAM_BASE[ADDR_W-1:BANK_AW+3]) begin
      if (addr_i.ram.bank) begin
        tgt_d = TGT_RAM1;
      end else begin
        tgt_d = TGT_RAM0;
      end
    end else if (addr_i.periph.region == PERIPH_BASE[ADDR_W-1 -: 4]) begin
      tgt_d = TGT_EXIT;
    end
  end

  assign ram0_req_o   = req_i && (tgt_d == TGT_RAM0);
  assign ram0_we_o    = we_i;
  assign ram0_addr_o  = addr_i.ram.word;
  assign ram0_be_o    = be_i;
  assign ram0_wdata_o = wdata_i;

  assign ram1_req_o   = req_i && (tgt_d == TGT_RAM1);
  assign ram1_we_o    = we_i;
  assign ram1_addr_o  = addr_i.ram.word;
  assign ram1_be_o    = be_i;
  assign ram1_wdata_o = wdata_i;

  assign exit_req_o   = req_i && (tgt_d == TGT_EXIT);
  assign exit_we_o    = we_i;
  assign exit_addr_o  = addr_i;
  assign exit_be_o    = be_i;
  assign exit_wdata_o = wdata_i;

  // unmapped requests are granted here
  always_comb begin
    case (tgt_d)
      TGT_RAM0: gnt_o = ram0_gnt_i;
      TGT_RAM1: gnt_o = ram1_gnt_i;
      TGT_EXIT: gnt_o = exit_gnt_i;
      default:  gnt_o = req_i;
    endcase
  end

  assign accept = req_i & gnt_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgt_q   <= TGT_NONE;
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
      if (accept) begin
        tgt_q <= tgt_d;
      end
    end
  end

  // response mux, error response made locally
  always_comb begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    case (tgt_q)
      TGT_RAM0: begin
        rvalid_o = ram0_rvalid_i;
        rdata_o  = ram0_rdata_i;
      end
      TGT_RAM1: begin
        rvalid_o = ram1_rvalid_i;
        rdata_o  = ram1_rdata_i;
      end
      TGT_EXIT: begin
        rvalid_o = exit_rvalid_i;
        rdata_o  = exit_rdata_i;
        err_o    = exit_err_i;
      end
      default: begin
        rvalid_o = valid_q;
        err_o    = valid_q;
      end
    endcase
  end

  a_one_slave_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0({ram0_req_o, ram1_req_o, exit_req_o})
  ) else $error("system_bus: more than one slave requested");

  a_rvalid_has_request: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rvalid_o |-> $past(accept)
  ) else $error("system_bus: response without an accepted transfer");

endmodule

/* logic/mini_mcu.sv */
// mini mcu memory system top
// one obi master port into the bus, two sram banks and exit control
module mini_mcu (
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [mcu_pkg::ADDR_W-1:0] addr_i,
  input  logic [3:0]                 be_i,
  input  mcu_pkg::mcu_data_t         wdata_i,

  output logic                       gnt_o,
  output logic                       rvalid_o,
  output mcu_pkg::mcu_data_t         rdata_o,
  output logic                       err_o,

  output mcu_pkg::mcu_data_t         exit_value_o,
  output logic                       exit_valid_o
);

  import mcu_pkg::*;

  logic               ram0_req, ram0_we, ram0_gnt, ram0_rvalid;
  logic [BANK_AW-1:0] ram0_addr;
  logic [3:0]         ram0_be;
  mcu_data_t          ram0_wdata, ram0_rdata;

  logic               ram1_req, ram1_we, ram1_gnt, ram1_rvalid;
  logic [BANK_AW-1:0] ram1_addr;
  logic [3:0]         ram1_be;
  mcu_data_t          ram1_wdata, ram1_rdata;

  logic               exit_req, exit_we, exit_gnt, exit_rvalid, exit_err;
  mcu_addr_u          exit_addr;
  logic [3:0]         exit_be;
  mcu_data_t          exit_wdata, exit_rdata;

  system_bus u_system_bus (
    .clk_i, .rst_i,
    .req_i, .we_i, .addr_i, .be_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o, .err_o,
    .ram0_req_o(ram0_req), .ram0_we_o(ram0_we), .ram0_addr_o(ram0_addr),
    .ram0_be_o(ram0_be), .ram0_wdata_o(ram0_wdata),
    .ram0_gnt_i(ram0_gnt), .ram0_rvalid_i(ram0_rvalid), .ram0_rdata_i(ram0_rdata),
    .ram1_req_o(ram1_req), .ram1_we_o(ram1_we), .ram1_addr_o(ram1_addr),
    .ram1_be_o(ram1_be), .ram1_wdata_o(ram1_wdata),
    .ram1_gnt_i(ram1_gnt), .ram1_rvalid_i(ram1_rvalid), .ram1_rdata_i(ram1_rdata),
    .exit_req_o(exit_req), .exit_we_o(exit_we), .exit_addr_o(exit_addr),
    .exit_be_o(exit_be), .exit_wdata_o(exit_wdata),
    .exit_gnt_i(exit_gnt), .exit_rvalid_i(exit_rvalid), .exit_rdata_i(exit_rdata),
    .exit_err_i(exit_err)
  );

  sram_bank #(.NUM_WORDS(BANK_WORDS)) u_ram0 (
    .clk_i, .rst_i,
    .req_i(ram0_req), .we_i(ram0_we), .addr_i(ram0_addr), .be_i(ram0_be),
    .wdata_i(ram0_wdata),
    .gnt_o(ram0_gnt), .rvalid_o(ram0_rvalid), .rdata_o(ram0_rdata)
  );

  sram_bank #(.NUM_WORDS(BANK_WORDS)) u_ram1 (
    .clk_i, .rst_i,
    .req_i(ram1_req), .we_i(ram1_we), .addr_i(ram1_addr), .be_i(ram1_be),
    .wdata_i(ram1_wdata),
    .gnt_o(ram1_gnt), .rvalid_o(ram1_rvalid), .rdata_o(ram1_rdata)
  );

  exit_ctrl u_exit_ctrl (
    .clk_i, .rst_i,
    .req_i(exit_req), .we_i(exit_we), .addr_i(exit_addr), .be_i(exit_be),
    .wdata_i(exit_wdata),
    .gnt_o(exit_gnt), .rvalid_o(exit_rvalid), .rdata_o(exit_rdata), .err_o(exit_err),
    .exit_value_o, .exit_valid_o
  );

endmodule

/* test/tb_mini_mcu.sv */
// testbench for the mini mcu memory system
// runs a table of obi transfers and checks every in-order response
module tb_mini_mcu;

  import mcu_pkg::*;

  localparam int MAX_ROWS = 32;

  logic      clk = 1'b0;
  logic      rst, req, we, gnt, rvalid, err, exit_valid;
  logic [ADDR_W-1:0] addr;
  logic [3:0] be;
  mcu_data_t wdata, rdata, exit_value;

  // stimulus table
  logic      row_we    [MAX_ROWS];
  logic [ADDR_W-1:0] row_addr [MAX_ROWS];
  logic [3:0] row_be   [MAX_ROWS];
  mcu_data_t row_wdata [MAX_ROWS];
  mcu_data_t row_rdata [MAX_ROWS];
  logic      row_err   [MAX_ROWS];
  logic      row_exit  [MAX_ROWS];
  int        n_rows = 0;

  int        exp_q [$];
  int        cur_row = 0;
  int        mon_idx;
  int        cycles = 0;
  int        data_errs = 0;
  int        flag_errs = 0;
  int        proto_errs = 0;
  mcu_data_t rand_a, rand_b, rand_c, rand_d, rand_e;

  mini_mcu u_mini_mcu (
    .clk_i(clk), .rst_i(rst),
    .req_i(req), .we_i(we), .addr_i(addr), .be_i(be), .wdata_i(wdata),
    .gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(rdata), .err_o(err),
    .exit_value_o(exit_value), .exit_valid_o(exit_valid)
  );

  always #20 clk = ~clk;

  // target as the memory map defines it
  function automatic tgt_sel_e classify(input logic [ADDR_W-1:0] a);
    if (a[31:11] == '0) begin
      return a[10] ? TGT_RAM1 : TGT_RAM0;
    end
    if (a[31:28] == 4'h2) begin
      return TGT_EXIT;
    end
    return TGT_NONE;
  endfunction

  task automatic add_row(input logic w, input logic [ADDR_W-1:0] a, input logic [3:0] b,
                         input mcu_data_t wd, input mcu_data_t rd, input logic e);
    row_we[n_rows]    = w;
    row_addr[n_rows]  = a;
    row_be[n_rows]    = b;
    row_wdata[n_rows] = wd;
    row_rdata[n_rows] = rd;
    row_err[n_rows]   = e;
    row_exit[n_rows]  = w && !e && (classify(a) == TGT_EXIT);
    n_rows++;
  endtask

  task automatic check_data(input string name, input mcu_data_t got, input mcu_data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // every response is due on the cycle after its grant
  always @(negedge clk) begin
    if (rvalid) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("response arrived with no transfer outstanding at cycle %0d", cycles);
      end else begin
        mon_idx = exp_q.pop_front();
        check_flag($sformatf("err_o [row %0d %s]", mon_idx, classify(row_addr[mon_idx]).name()),
                   err, row_err[mon_idx]);
        if (!row_we[mon_idx] || row_err[mon_idx]) begin
          check_data($sformatf("rdata_o [row %0d %s]", mon_idx,
                     classify(row_addr[mon_idx]).name()), rdata, row_rdata[mon_idx]);
        end
        if (row_exit[mon_idx]) begin
          check_flag("exit_valid_o", exit_valid, 1'b1);
          check_data("exit_value_o", exit_value, row_wdata[mon_idx]);
        end
      end
    end else if (exp_q.size() != 0) begin
      mon_idx = exp_q.pop_front();
      proto_errs++;
      $display("no response one cycle after the grant of row %0d", mon_idx);
    end
    if (req && gnt) begin
      exp_q.push_back(cur_row);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (n_rows > 0 && cycles > 4 * n_rows + 100) begin
      $display("timeout after %0d cycles, run did not complete", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    rst   <= 1'b1;
    req   <= 1'b0;
    we    <= 1'b0;
    addr  <= '0;
    be    <= 4'h0;
    wdata <= '0;

    void'($urandom(32'hf25b));
    rand_a = $urandom();
    rand_b = $urandom();
    rand_c = $urandom();
    rand_d = $urandom();
    rand_e = $urandom();

    // bank select, same word index in both banks
    add_row(1'b1, 32'h0000_0014, 4'hf, rand_a, '0, 1'b0);
    add_row(1'b1, 32'h0000_0414, 4'hf, rand_b, '0, 1'b0);
    add_row(1'b0, 32'h0000_0014, 4'hf, '0, rand_a, 1'b0);
    add_row(1'b0, 32'h0000_0414, 4'hf, '0, rand_b, 1'b0);
    // byte lanes 0 and 2 only
    add_row(1'b1, 32'h0000_0020, 4'hf, 32'h1122_3344, '0, 1'b0);
    add_row(1'b1, 32'h0000_0020, 4'b0101, 32'haabb_ccdd, '0, 1'b0);
    add_row(1'b0, 32'h0000_0020, 4'hf, '0, 32'h11bb_33dd, 1'b0);
    // exit register
    add_row(1'b1, 32'h2000_0000, 4'hf, rand_e, '0, 1'b0);
    add_row(1'b0, 32'h2000_0000, 4'hf, '0, rand_e, 1'b0);
    // alternating targets, one per cycle
    add_row(1'b1, 32'h0000_0040, 4'hf, rand_c, '0, 1'b0);
    add_row(1'b1, 32'h0000_0440, 4'hf, rand_d, '0, 1'b0);
    add_row(1'b0, 32'h0000_0040, 4'hf, '0, rand_c, 1'b0);
    add_row(1'b0, 32'h2000_0000, 4'hf, '0, rand_e, 1'b0);
    add_row(1'b0, 32'h0000_0440, 4'hf, '0, rand_d, 1'b0);
    // unmapped ram region and unused register index
    add_row(1'b0, 32'h0000_0800, 4'hf, '0, '0, 1'b1);
    add_row(1'b0, 32'h2000_0004, 4'hf, '0, '0, 1'b1);
    add_row(1'b1, 32'h0000_0c00, 4'hf, 32'hdead_beef, '0, 1'b1);
    add_row(1'b0, 32'h2000_0000, 4'hf, '0, rand_e, 1'b0);
    add_row(1'b0, 32'h0000_0414, 4'hf, '0, rand_b, 1'b0);

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // idle state right after reset
    @(negedge clk);
    check_flag("gnt_o", gnt, 1'b0);
    check_flag("rvalid_o", rvalid, 1'b0);
    check_flag("err_o", err, 1'b0);
    check_flag("exit_valid_o", exit_valid, 1'b0);
    check_data("exit_value_o", exit_value, '0);

    @(posedge clk);
    for (int i = 0; i < n_rows; i++) begin
      cur_row <= i;
      req     <= 1'b1;
      we      <= row_we[i];
      addr    <= row_addr[i];
      be      <= row_be[i];
      wdata   <= row_wdata[i];
      @(negedge clk);
      while (!gnt) begin
        @(negedge clk);
      end
      @(posedge clk);
    end
    req <= 1'b0;
    we  <= 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);

    // flag stays set after later traffic
    check_flag("gnt_o", gnt, 1'b0);
    check_flag("exit_valid_o", exit_valid, 1'b1);
    check_data("exit_value_o", exit_value, rand_e);

    $display("errors: data %0d, flag %0d, protocol %0d", data_errs, flag_errs, proto_errs);
    if (data_errs + flag_errs + proto_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
logic/mcu_pkg.sv
logic/sram_bank.sv
logic/exit_ctrl.sv
logic/system_bus.sv
logic/mini_mcu.sv
test/tb_mini_mcu.sv

/* Makefile */
SIM      := verilator
VFLAGS   := --binary --timing --assert
TOP      := tb_mini_mcu
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $* -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
